// File: src/rename_cfg_pkg.sv
package rename_cfg_pkg;

	// Register files
	localparam int ARCH_REGS = 32; // Architectural registers seen by software
	localparam int PHYS_REGS = 64; // Physical registers behind the rename map

	// Reorder buffer depth
	localparam int ROB_SIZE = 16;

	// Tags not held by the architectural map at any time
	localparam int FREE_SIZE = PHYS_REGS - ARCH_REGS;

	// Index and tag widths
	localparam int ARCH_W    = $clog2(ARCH_REGS); // 5 bits
	localparam int PHYS_W    = $clog2(PHYS_REGS); // 6 bits
	localparam int ROB_IDX_W = $clog2(ROB_SIZE);  // 4 bits

	// The free list must be able to hold every tag
	// outside the committed map, so its depth is fixed by the two register files.
	// Head, tail and committed head each carry one extra wrap bit
	// on top of the index, which tells a full queue from an empty one

	// The ROB count carries one extra bit as well,
	// so that a full buffer of ROB_SIZE entries can be represented

	// Tags 0 to ARCH_REGS-1 form the identity map after reset,
	// tags ARCH_REGS to PHYS_REGS-1 start out in the free list

endpackage

// File: src/rename_types_pkg.sv
package rename_types_pkg;

	typedef logic [rename_cfg_pkg::ARCH_W-1:0] arch_reg_t;
	typedef logic [rename_cfg_pkg::PHYS_W-1:0] phys_tag_t;

	// New instruction at dispatch, destination only
	typedef struct packed {
		arch_reg_t arch_dst;
	} dispatch_req_t;

	// Tags handed back in the handshake cycle
	typedef struct packed {
		phys_tag_t new_tag; // Fresh tag from the free list
		phys_tag_t old_tag; // Previous mapping of arch_dst
	} dispatch_rsp_t;

	// Common data bus broadcast
	typedef struct packed {
		logic      valid;
		phys_tag_t tag;
	} cdb_t;

	typedef struct packed {
		logic      busy;  // Entry holds an instruction in flight
		logic      ready; // Result tag has been broadcast
		arch_reg_t arch_dst;
		phys_tag_t new_tag;
		phys_tag_t old_tag;
	} rob_entry_t;

	typedef struct packed {
		arch_reg_t arch_dst;
		phys_tag_t new_tag; // Becomes the architectural mapping
		phys_tag_t old_tag; // Goes back to the free list
	} retire_t;

endpackage

// File: src/rob_tag_cam.sv
`timescale 1ns/1ps

module rob_tag_cam (
	input  rename_types_pkg::rob_entry_t [rename_cfg_pkg::ROB_SIZE-1:0] entries,
	input  rename_types_pkg::cdb_t                                      cdb,
	output logic [rename_cfg_pkg::ROB_SIZE-1:0]                          hit
);
	import rename_cfg_pkg::*;

	// One comparator per entry, all in parallel
	always_comb begin
		hit = '0;
		if (cdb.valid) begin
			for (int i = 0; i < ROB_SIZE; i++) begin
				// Idle entries may hold stale tags, so busy must qualify the match
				hit[i] = entries[i].busy && (entries[i].new_tag == cdb.tag);
			end
		end
	end

	// Tags are unique among busy entries, so at most one bit is set
	// while the free list and the map stay consistent.
	// A broadcast for a tag that is no longer in flight, for
	// example after a flush, leaves the vector at zero

	// The ROB ORs the vector into its ready bits,
	// entries already marked ready are unaffected

endmodule

// File: src/rob.sv
`timescale 1ns/1ps

module rob (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            flush,

	// Dispatch handshake
	input  logic                            dispatch_valid,
	input  rename_types_pkg::dispatch_req_t dispatch_req,
	output logic                            dispatch_ready,
	output rename_types_pkg::dispatch_rsp_t dispatch_rsp,

	// Free list and map table side
	input  rename_types_pkg::phys_tag_t     free_tag,
	input  logic                            avail,
	input  rename_types_pkg::phys_tag_t     old_tag,
	output logic                            alloc,
	output logic                            spec_we,
	output rename_types_pkg::phys_tag_t     spec_tag,

	input  rename_types_pkg::cdb_t          cdb,

	// Retire handshake
	output logic                            retire_valid,
	output rename_types_pkg::retire_t       retire,
	input  logic                            retire_ready,
	output logic                            retire_fire
);
	import rename_cfg_pkg::*;
	import rename_types_pkg::*;

	rob_entry_t [ROB_SIZE-1:0] entries;
	logic [ROB_IDX_W-1:0]      head;
	logic [ROB_IDX_W-1:0]      tail;
	logic [ROB_IDX_W:0]        count; // Busy entries, 0 to ROB_SIZE
	logic [ROB_SIZE-1:0]       cam_hit;
	logic                      rob_full;
	logic                      dispatch_fire;
	rob_entry_t                head_entry;

	rob_tag_cam cam_i (
		.entries (entries),
		.cdb     (cdb),
		.hit     (cam_hit)
	);

	assign rob_full   = (count == (ROB_IDX_W+1)'(ROB_SIZE));
	assign head_entry = entries[head];

	// No new work while the pipeline is being flushed
	assign dispatch_ready = !flush && avail && !rob_full;
	assign dispatch_fire  = dispatch_valid && dispatch_ready;

	assign dispatch_rsp.new_tag = free_tag;
	assign dispatch_rsp.old_tag = old_tag;

	assign alloc    = dispatch_fire; // Pops the free list
	assign spec_we  = dispatch_fire;
	assign spec_tag = free_tag;

	// Head presents only once its result is on the register file
	assign retire_valid = !flush && head_entry.busy && head_entry.ready;
	assign retire_fire  = retire_valid && retire_ready;

	assign retire.arch_dst = head_entry.arch_dst;
	assign retire.new_tag  = head_entry.new_tag;
	assign retire.old_tag  = head_entry.old_tag;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			entries <= '0;
			head    <= '0;
			tail    <= '0;
			count   <= '0;
		end else if (flush) begin
			// Everything in flight is younger than the mispredicted branch
			for (int i = 0; i < ROB_SIZE; i++) begin
				entries[i].busy  <= 1'b0;
				entries[i].ready <= 1'b0;
			end
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			// Wake-up from the CDB
			for (int i = 0; i < ROB_SIZE; i++) begin
				if (cam_hit[i])
					entries[i].ready <= 1'b1;
			end

			if (retire_fire) begin
				entries[head].busy  <= 1'b0;
				entries[head].ready <= 1'b0;
				head                <= head + 1'b1; // Wraps at ROB_SIZE
			end

			if (dispatch_fire) begin
				entries[tail] <= '{busy: 1'b1, ready: 1'b0, arch_dst: dispatch_req.arch_dst,
					new_tag: free_tag, old_tag: old_tag};
				tail <= tail + 1'b1;
			end

			case ({dispatch_fire, retire_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: src/free_list.sv
`timescale 1ns/1ps

module free_list (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic                        flush,
	input  logic                        alloc,      // Pop at dispatch
	output rename_types_pkg::phys_tag_t free_tag,
	output logic                        avail,
	input  logic                        retire_fire,
	input  rename_types_pkg::retire_t   retire
);
	import rename_cfg_pkg::*;
	import rename_types_pkg::*;

	// Pointers with one wrap bit above the index
	typedef logic [$clog2(FREE_SIZE):0]   ptr_t;
	typedef logic [$clog2(FREE_SIZE)-1:0] idx_t;

	phys_tag_t [FREE_SIZE-1:0] tags;
	ptr_t                      head;
	ptr_t                      tail;
	ptr_t                      commit_head; // Head as seen by retired instructions only
	idx_t                      head_idx;
	idx_t                      tail_idx;

	assign head_idx = head[$clog2(FREE_SIZE)-1:0];
	assign tail_idx = tail[$clog2(FREE_SIZE)-1:0];

	assign free_tag = tags[head_idx];
	assign avail    = (head != tail);

	// Entries between commit_head and head are tags taken by instructions
	// still in flight. They are never overwritten, since the tail stays exactly
	// FREE_SIZE ahead of commit_head, so a flush can hand them out again
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < FREE_SIZE; i++) begin
				tags[i] <= phys_tag_t'(ARCH_REGS + i); // Tags above the identity map
			end
			head        <= '0;
			tail        <= ptr_t'(FREE_SIZE);   // Queue starts full
			commit_head <= '0;
		end else begin
			if (retire_fire) begin
				tags[tail_idx] <= retire.old_tag;
				tail           <= tail + 1'b1;
				commit_head    <= commit_head + 1'b1; // One tag per retired instruction
			end

			if (flush)
				head <= commit_head;
			else if (alloc)
				head <= head + 1'b1;
		end
	end

	// Retire and dispatch are both blocked in the flush cycle, so the
	// commit_head copied above is already final for that cycle

endmodule

// File: src/map_table.sv
`timescale 1ns/1ps

module map_table (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            flush,

	// Speculative side, used at dispatch
	input  rename_types_pkg::dispatch_req_t dispatch_req,
	input  logic                            spec_we,
	input  rename_types_pkg::phys_tag_t     spec_tag,
	output rename_types_pkg::phys_tag_t     old_tag,

	// Architectural side, used at retire
	input  logic                            retire_fire,
	input  rename_types_pkg::retire_t       retire
);
	import rename_cfg_pkg::*;
	import rename_types_pkg::*;

	phys_tag_t [ARCH_REGS-1:0] spec_map;
	phys_tag_t [ARCH_REGS-1:0] arch_map;

	// Combinational read, the write of this cycle shows next cycle
	assign old_tag = spec_map[dispatch_req.arch_dst];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				spec_map[i] <= phys_tag_t'(i); // Identity map
			end
		end else if (flush) begin
			spec_map <= arch_map; // Roll back to the committed state
		end else if (spec_we) begin
			spec_map[dispatch_req.arch_dst] <= spec_tag;
		end
	end

	// Updated only by retiring instructions, in program order
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				arch_map[i] <= phys_tag_t'(i);
			end
		end else if (retire_fire) begin
			arch_map[retire.arch_dst] <= retire.new_tag;
		end
	end

	// The two maps only differ in registers written by instructions
	// still in the ROB. Copying the whole architectural map on a flush
	// is therefore enough to undo every speculative write at once,
	// without walking the ROB backwards

endmodule

// File: src/rename_top.sv
`timescale 1ns/1ps

module rename_top (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            flush,          // Branch mispredict, one cycle

	input  logic                            dispatch_valid,
	input  rename_types_pkg::dispatch_req_t dispatch_req,
	output logic                            dispatch_ready,
	output rename_types_pkg::dispatch_rsp_t dispatch_rsp,

	input  rename_types_pkg::cdb_t          cdb,            // Always accepted

	output logic                            retire_valid,
	output rename_types_pkg::retire_t       retire,
	input  logic                            retire_ready
);
	import rename_types_pkg::*;

	phys_tag_t free_tag;
	logic      avail;
	logic      alloc;
	phys_tag_t old_tag;
	logic      spec_we;
	phys_tag_t spec_tag;
	logic      retire_fire; // Retire handshake, shared by free list and map

	rob rob_i (
		.clock          (clock),
		.arst_n         (arst_n),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_req   (dispatch_req),
		.dispatch_ready (dispatch_ready),
		.dispatch_rsp   (dispatch_rsp),
		.free_tag       (free_tag),
		.avail          (avail),
		.old_tag        (old_tag),
		.alloc          (alloc),
		.spec_we        (spec_we),
		.spec_tag       (spec_tag),
		.cdb            (cdb),
		.retire_valid   (retire_valid),
		.retire         (retire),
		.retire_ready   (retire_ready),
		.retire_fire    (retire_fire)
	);

	free_list free_list_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.flush       (flush),
		.alloc       (alloc),
		.free_tag    (free_tag),
		.avail       (avail),
		.retire_fire (retire_fire),
		.retire      (retire)
	);

	map_table map_table_i (
		.clock        (clock),
		.arst_n       (arst_n),
		.flush        (flush),
		.dispatch_req (dispatch_req),
		.spec_we      (spec_we),
		.spec_tag     (spec_tag),
		.old_tag      (old_tag),
		.retire_fire  (retire_fire),
		.retire       (retire)
	);

endmodule

// File: sim/rename_properties.sv
`timescale 1ns/1ps

module rename_properties (
	input logic                      clock,
	input logic                      arst_n,
	input logic                      flush,
	input logic                      dispatch_valid,
	input logic                      dispatch_ready,
	input logic                      retire_valid,
	input logic                      retire_ready,
	input rename_types_pkg::retire_t retire
);
	import rename_cfg_pkg::*;

	int                 failures = 0; // Polled by the testbench
	logic [ROB_IDX_W:0] in_flight;    // Dispatched and neither retired nor flushed
	logic               dispatch_fire;
	logic               retire_fire;

	assign dispatch_fire = dispatch_valid && dispatch_ready;
	assign retire_fire   = retire_valid && retire_ready;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			in_flight <= '0;
		else if (flush)
			in_flight <= '0;
		else if (dispatch_fire && !retire_fire)
			in_flight <= in_flight + 1'b1;
		else if (retire_fire && !dispatch_fire)
			in_flight <= in_flight - 1'b1;
	end

	// A mispredict empties the ROB
	no_retire_after_flush: assert property (
		@(posedge clock) disable iff (!arst_n) flush |=> !retire_valid
	) else begin
		failures++;
		$error("retire_valid high in the cycle after a flush");
	end

	full_blocks_dispatch: assert property (
		@(posedge clock) disable iff (!arst_n) (in_flight == ROB_SIZE) |-> !dispatch_ready
	) else begin
		failures++;
		$error("dispatch_ready high with all ROB entries busy");
	end

	// Head entry holds while the consumer stalls
	retire_stable_when_stalled: assert property (
		@(posedge clock) disable iff (!arst_n)
		retire_valid && !retire_ready |=> $stable(retire)
	) else begin
		failures++;
		$error("retire fields changed while retire_ready was low");
	end

endmodule

bind rename_top rename_properties properties_i (
	.clock          (clock),
	.arst_n         (arst_n),
	.flush          (flush),
	.dispatch_valid (dispatch_valid),
	.dispatch_ready (dispatch_ready),
	.retire_valid   (retire_valid),
	.retire_ready   (retire_ready),
	.retire         (retire)
);

// File: sim/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;
	import rename_types_pkg::*;

	localparam int    TIMEOUT_CYCLES = 40;
	localparam string GOLDEN_FILE    = "sim/rename_golden.txt";

	logic          clock;
	logic          arst_n;
	logic          flush;
	logic          dispatch_valid;
	dispatch_req_t dispatch_req;
	logic          dispatch_ready;
	dispatch_rsp_t dispatch_rsp;
	cdb_t          cdb;
	logic          retire_valid;
	retire_t       retire;
	logic          retire_ready;

	int               fd;
	int               n;
	int               cmd_count; // Commands executed so far
	int               stalls;
	logic [63:0]      cmd;
	logic [8*160-1:0] comment;
	logic [7:0]       f0;
	logic [7:0]       f1;
	logic [7:0]       f2;
	logic [7:0]       in_flight_tags[$]; // Expected new tags of dispatched, unretired entries

	rename_top dut_i (
		.clock          (clock),
		.arst_n         (arst_n),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_req   (dispatch_req),
		.dispatch_ready (dispatch_ready),
		.dispatch_rsp   (dispatch_rsp),
		.cdb            (cdb),
		.retire_valid   (retire_valid),
		.retire         (retire),
		.retire_ready   (retire_ready)
	);

	always #2 clock = ~clock; // 4 ns period

	task automatic stop_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Run stopped at command %0d", cmd_count);
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got == exp) else begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h at command %0d",
				name, got, exp, cmd_count);
			stop_run();
		end
	endtask

	task automatic expect_fields(input int want);
		if (n != want) begin
			$display("Golden file command %0d has %0d fields instead of %0d", cmd_count, n, want);
			stop_run();
		end
	endtask

	// Inputs change 0.5 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#0.5;
	endtask

	// Outputs are sampled at falling edges, away from any input change
	task automatic wait_high(input bit on_retire);
		int waited;
		waited = 0;
		@(negedge clock);
		while (!(on_retire ? retire_valid : dispatch_ready)) begin
			waited++;
			if (waited > TIMEOUT_CYCLES) begin
				$display("Timed out waiting for %s at command %0d",
					on_retire ? "retire_valid" : "dispatch_ready", cmd_count);
				stop_run();
			end
			@(negedge clock);
		end
	endtask

	task automatic dispatch_and_check(input logic [7:0] arch, input logic [7:0] exp_new,
		input logic [7:0] exp_old);
		dispatch_valid        = 1'b1;
		dispatch_req.arch_dst = arch_reg_t'(arch);
		wait_high(1'b0);
		check_value("dispatch_rsp.new_tag", dispatch_rsp.new_tag, exp_new); // Handshake cycle
		check_value("dispatch_rsp.old_tag", dispatch_rsp.old_tag, exp_old);
		next_cycle();
		dispatch_valid = 1'b0;
		in_flight_tags.push_back(exp_new);
	endtask

	task automatic broadcast_tag(input logic [7:0] tag);
		cdb.valid = 1'b1;
		cdb.tag   = phys_tag_t'(tag);
		next_cycle();
		cdb.valid = 1'b0;
	endtask

	task automatic retire_and_check(input logic [7:0] arch, input logic [7:0] exp_new,
		input logic [7:0] exp_old, input int stall_cycles);
		retire_ready = (stall_cycles == 0); // Ready at once when no stall is asked for
		wait_high(1'b1);
		if (stall_cycles > 0) begin
			repeat (stall_cycles) next_cycle(); // Consumer holds retire_ready low
			retire_ready = 1'b1;
			@(negedge clock);
			check_value("retire_valid", retire_valid, 8'h01);
		end
		check_value("retire.arch_dst", retire.arch_dst, arch);
		check_value("retire.new_tag", retire.new_tag, exp_new);
		check_value("retire.old_tag", retire.old_tag, exp_old);
		next_cycle();
		retire_ready = 1'b0;
		if (in_flight_tags.size() > 0)
			in_flight_tags.delete(0);
	endtask

	task automatic flush_pipeline();
		// Wake the oldest entry so that a retirement is pending when the flush hits
		if (in_flight_tags.size() > 0)
			broadcast_tag(in_flight_tags[0]);
		flush = 1'b1;
		@(negedge clock);
		check_value("dispatch_ready", dispatch_ready, 8'h00);
		check_value("retire_valid", retire_valid, 8'h00);
		next_cycle();
		flush = 1'b0;
		in_flight_tags.delete();
	endtask

	task automatic check_idle(input logic [7:0] exp_dready, input logic [7:0] exp_rvalid);
		@(negedge clock);
		check_value("dispatch_ready", dispatch_ready, exp_dready);
		check_value("retire_valid", retire_valid, exp_rvalid);
		next_cycle();
	endtask

	// Concurrent assertions bound into the DUT count their failures
	always @(negedge clock) begin
		if (dut_i.properties_i.failures != 0) begin
			$display("A concurrent assertion on rename_top failed");
			stop_run();
		end
	end

	initial begin
		clock          = 1'b0;
		arst_n         = 1'b0;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_req   = '0;
		cdb            = '0;
		retire_ready   = 1'b0;
		cmd_count      = 0;

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s for reading", GOLDEN_FILE);
			stop_run();
		end

		repeat (2) @(posedge clock);
		#0.5;
		arst_n = 1'b1;

		while ($fscanf(fd, " %s", cmd) == 1) begin
			if (cmd == "#") begin
				n = $fgets(comment, fd); // Skip the rest of a comment line
			end else begin
				cmd_count++;
				case (cmd)
					"D": begin
						n = $fscanf(fd, " %h %h %h", f0, f1, f2);
						expect_fields(3);
						dispatch_and_check(f0, f1, f2);
					end
					"B": begin
						n = $fscanf(fd, " %h", f0);
						expect_fields(1);
						broadcast_tag(f0);
					end
					"R": begin
						n = $fscanf(fd, " %h %h %h %d", f0, f1, f2, stalls);
						expect_fields(4);
						retire_and_check(f0, f1, f2, stalls);
					end
					"F": flush_pipeline();
					"N": begin
						n = $fscanf(fd, " %h %h", f0, f1);
						expect_fields(2);
						check_idle(f0, f1);
					end
					default: begin
						$display("Unknown command in golden file at command %0d", cmd_count);
						stop_run();
					end
				endcase
			end
		end
		$fclose(fd);

		if (dut_i.properties_i.failures == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "%0d concurrent assertion failures", dut_i.properties_i.failures);
		end
	end

endmodule

// File: sim/rename_golden.txt
# D arch new_tag old_tag | B tag | R arch new_tag old_tag stall_cycles | F | N dready rvalid
# All fields are hex except stall_cycles which is decimal
D 01 20 01
D 02 21 02
D 01 22 20
# Youngest broadcast first
B 22
B 21
B 20
R 01 20 01 0
R 02 21 02 2
R 01 22 20 0
# Sixteen dispatches fill the ROB while retire_ready stays low
D 03 23 03
D 04 24 04
D 05 25 05
D 06 26 06
D 07 27 07
D 08 28 08
D 09 29 09
D 0a 2a 0a
D 0b 2b 0b
D 0c 2c 0c
D 0d 2d 0d
D 0e 2e 0e
D 0f 2f 0f
D 10 30 10
D 11 31 11
D 12 32 12
N 0 0
B 23
R 03 23 03 1
N 1 0
B 24
B 25
B 26
B 27
B 28
B 29
B 2a
B 2b
B 2c
B 2d
B 2e
B 2f
B 30
B 31
B 32
R 04 24 04 0
R 05 25 05 0
R 06 26 06 0
R 07 27 07 0
R 08 28 08 0
R 09 29 09 0
R 0a 2a 0a 0
R 0b 2b 0b 0
R 0c 2c 0c 0
R 0d 2d 0d 0
R 0e 2e 0e 0
R 0f 2f 0f 0
R 10 30 10 0
R 11 31 11 0
R 12 32 12 0
# Last initial tags, then the retired old tags in retire order
D 13 33 13
D 14 34 14
D 15 35 15
D 16 36 16
D 17 37 17
D 18 38 18
D 19 39 19
D 1a 3a 1a
D 1b 3b 1b
D 1c 3c 1c
D 1d 3d 1d
D 1e 3e 1e
D 1f 3f 1f
D 01 01 22
D 02 02 21
D 01 20 01
# Mispredict with sixteen entries in flight
F
N 1 0
D 01 33 22
D 1f 34 1f

// File: flist.f
src/rename_cfg_pkg.sv
src/rename_types_pkg.sv
src/rob_tag_cam.sv
src/rob.sv
src/free_list.sv
src/map_table.sv
src/rename_top.sv
sim/rename_properties.sv
sim/rename_tb.sv

// File: Bender.yml
package:
  name: rename_subsystem

sources:
  - src/rename_cfg_pkg.sv
  - src/rename_types_pkg.sv
  - src/rob_tag_cam.sv
  - src/rob.sv
  - src/free_list.sv
  - src/map_table.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - sim/rename_properties.sv
      - sim/rename_tb.sv
